/* src.f */
+incdir+bench
common/dsp_const_pkg.sv
common/dsp_cfg_pkg.sv
source/lane_delay.sv
ffe/ffe_slicer.sv
channel/channel_error.sv
source/dsp_cfg_regs.sv
source/rx_datapath_top.sv
bench/tb_rx_datapath.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f \
    --top-module tb_rx_datapath -o tb_rx_datapath
./obj_dir/tb_rx_datapath | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

/* bench/tb_rx_model.svh */
`ifndef TB_RX_MODEL_SVH
`define TB_RX_MODEL_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
        lfsr_state = lfsr_next(lfsr_state);
        r = {r[30:0], lfsr_state[31]};
    end
    return r;
endfunction

function automatic int clamp(input int v, input int w);
    int hi;
    hi = (1 << (w - 1)) - 1;
    if (v > hi) begin
        return hi;
    end
    if (v < -hi - 1) begin
        return -hi - 1;
    end
    return v;
endfunction

// Read-back of a register after a write of d
function automatic logic [15:0] reg_expect(input logic [3:0] adr, input logic [15:0] d);
    case (adr)
        reg_ffe_w0, reg_ffe_w1, reg_ffe_w2,
        reg_chan_h0, reg_chan_h1, reg_chan_h2: return {{8{d[7]}}, d[7:0]};
        reg_thresh:                            return {{6{d[9]}}, d[9:0]};
        reg_ffe_shift, reg_chan_shift:         return {12'd0, d[3:0]};
        default:                               return 16'd0;
    endcase
endfunction

// Symbols before reset count as zero codes
function automatic int sym_at(input int s);
    if (s < 0) begin
        return 0;
    end
    return int'($signed(sym_log[s]));
endfunction

function automatic int ffe_at(input int s, input dsp_cfg_t c);
    int acc;
    acc = 0;
    for (int k = 0; k < ffe_taps; k++) begin
        acc += sym_at(s - k) * int'($signed(c.ffe_weight[k]));
    end
    return clamp(acc >>> c.ffe_shift, ffe_out_width);
endfunction

// Slicer threshold is taken one edge after the FFE config of the block
function automatic int bit_at(input int s);
    int n;
    int ffe;
    if (s < 0) begin
        n   = -1;
        ffe = 0;
    end else begin
        n   = s / lane_count;
        ffe = ffe_at(s, cfg_log[n]);
    end
    return (ffe >= int'($signed(cfg_log[n + 1].thresh))) ? 1 : 0;
endfunction

// Channel taps are taken two edges after the FFE of the block
function automatic int err_at(input int s);
    int       acc;
    dsp_cfg_t c;
    c   = cfg_log[s / lane_count + 2];
    acc = 0;
    for (int k = 0; k < chan_taps; k++) begin
        acc += (2 * bit_at(s - k) - 1) * int'($signed(c.chan_est[k]));
    end
    acc = clamp(acc >>> c.chan_shift, err_width);
    return clamp(acc - sym_at(s), err_width);
endfunction

`endif

/* bench/tb_rx_datapath.sv */
`default_nettype none

module tb_rx_datapath;

    import dsp_const_pkg::*;
    import dsp_cfg_pkg::*;

    logic        clk;
    logic        rst_n;
    code_blk_t   codes;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    bit_blk_t    bits;
    err_blk_t    errs;
    logic        valid;

    logic [31:0] lfsr_state;
    dsp_cfg_t    cfg_shadow;
    code_t       sym_log[$];
    dsp_cfg_t    cfg_log[$];
    logic        rst_seen;
    int          bit_errors;
    int          err_errors;
    int          other_errors;

    `include "tb_rx_model.svh"

    rx_datapath_top UUT (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .codes_i  (codes),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .bits_o   (bits),
        .err_o    (errs),
        .valid_o  (valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        codes <= code_blk_t'(rand_bits(32));
    end

    // Codes and config that each edge hands to the DUT
    always @(posedge clk) begin
        if (!rst_n) begin
            sym_log.delete();
            cfg_log.delete();
            cfg_shadow = '0;
            rst_seen   = 1'b1;
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                sym_log.push_back(codes[i]);
            end
            cfg_log.push_back(cfg_shadow);
        end
    end

    // Outputs after edge m belong to block m-3
    always @(negedge clk) begin
        int n;
        int s;
        if (rst_seen) begin
            if (valid !== 1'(cfg_log.size() >= 4)) begin
                $display("error at %0t: valid_o is %b, expected %0d", $time, valid,
                         cfg_log.size() >= 4);
                other_errors++;
            end
            if (cfg_log.size() >= 4) begin
                n = cfg_log.size() - 4;
                for (int i = 0; i < lane_count; i++) begin
                    s = n * lane_count + i;
                    if (bits[i] !== 1'(bit_at(s))) begin
                        $display("error at %0t: block %0d lane %0d bits_o %b, expected %0d",
                                 $time, n, i, bits[i], bit_at(s));
                        bit_errors++;
                    end
                    if (int'($signed(errs[i])) !== err_at(s)) begin
                        $display("error at %0t: block %0d lane %0d err_o %0d, expected %0d",
                                 $time, n, i, $signed(errs[i]), err_at(s));
                        err_errors++;
                    end
                end
            end
        end
    end

    task automatic shadow_write(input logic [3:0] addr, input logic [15:0] d);
        case (addr)
            reg_ffe_w0:     cfg_shadow.ffe_weight[0] = d[7:0];
            reg_ffe_w1:     cfg_shadow.ffe_weight[1] = d[7:0];
            reg_ffe_w2:     cfg_shadow.ffe_weight[2] = d[7:0];
            reg_ffe_shift:  cfg_shadow.ffe_shift     = d[3:0];
            reg_thresh:     cfg_shadow.thresh        = d[9:0];
            reg_chan_h0:    cfg_shadow.chan_est[0]   = d[7:0];
            reg_chan_h1:    cfg_shadow.chan_est[1]   = d[7:0];
            reg_chan_h2:    cfg_shadow.chan_est[2]   = d[7:0];
            reg_chan_shift: cfg_shadow.chan_shift    = d[3:0];
            default: ;
        endcase
    endtask

    task automatic wb_transfer(input logic write, input logic [3:0] addr,
                               input logic [15:0] wdata, output logic [15:0] rdata);
        int cycles;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: write, adr: addr, dat: wdata, sel: 2'b11};
        cycles = 0;
        @(negedge clk);
        while (wb_rsp.ack !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        rdata = wb_rsp.dat;
        if (wb_rsp.ack !== 1'b1) begin
            $display("wishbone transfer to address %0d timed out waiting for ack", addr);
            other_errors++;
        end else if (write) begin
            shadow_write(addr, wdata);
        end
        @(posedge clk);
        wb_req <= '0;
        @(negedge clk);
        if (wb_rsp.ack !== 1'b0) begin
            $display("error at %0t: ack held for more than one cycle", $time);
            other_errors++;
        end
    endtask

    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (valid !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (valid !== 1'b1) begin
            $display("timed out waiting for valid_o after reset");
            other_errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
    endtask

    task automatic run_blocks(input int count);
        repeat (count) @(negedge clk);
    endtask

    initial begin
        logic [15:0] d;
        logic [15:0] rd;
        int          n;
        rst_n        = 1'b0;
        codes        = '0;
        wb_req       = '0;
        lfsr_state   = 32'h1738;
        cfg_shadow   = '0;
        rst_seen     = 1'b0;
        bit_errors   = 0;
        err_errors   = 0;
        other_errors = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        wait_valid();

        // Write and read back every address
        for (int a = 0; a < 16; a++) begin
            d = 16'(rand_bits(16));
            wb_transfer(1'b1, 4'(a), d, rd);
            wb_transfer(1'b0, 4'(a), 16'h0, rd);
            if (rd !== reg_expect(4'(a), d)) begin
                $display("error at %0t: register %0d read %h, expected %h", $time, a, rd,
                         reg_expect(4'(a), d));
                other_errors++;
            end
        end

        // Identity FFE
        wb_transfer(1'b1, reg_ffe_shift, 16'd2, rd);
        wb_transfer(1'b1, reg_ffe_w0, 16'd4, rd);
        wb_transfer(1'b1, reg_ffe_w1, 16'd0, rd);
        wb_transfer(1'b1, reg_ffe_w2, 16'd0, rd);
        wb_transfer(1'b1, reg_thresh, 16'd0, rd);
        run_blocks(4);
        repeat (20) begin
            @(negedge clk);
            for (int i = 0; i < lane_count; i++) begin
                n = (cfg_log.size() - 4) * lane_count + i;
                if (bits[i] !== ($signed(sym_log[n]) >= 0)) begin
                    $display("error at %0t: lane %0d bit does not follow code sign",
                             $time, i);
                    bit_errors++;
                end
            end
        end

        for (int a = 0; a < 3; a++) begin
            wb_transfer(1'b1, 4'(32'(reg_ffe_w0) + a), 16'(rand_bits(16)), rd);
            wb_transfer(1'b1, 4'(32'(reg_chan_h0) + a), 16'(rand_bits(16)), rd);
        end
        wb_transfer(1'b1, reg_ffe_shift, 16'(rand_bits(2) + 32'd3), rd);
        wb_transfer(1'b1, reg_chan_shift, 16'(rand_bits(2)), rd);
        d = 16'(rand_bits(6));
        wb_transfer(1'b1, reg_thresh, {{10{d[5]}}, d[5:0]}, rd);
        run_blocks(200);

        // New threshold while the stream runs
        d = 16'(rand_bits(6));
        wb_transfer(1'b1, reg_thresh, {{10{d[5]}}, d[5:0]}, rd);
        run_blocks(40);

        apply_reset();
        wait_valid();
        run_blocks(30);

        $display("errors: bits %0d, error values %0d, other %0d",
                 bit_errors, err_errors, other_errors);
        if (bit_errors + err_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/rx_datapath_top.sv */
`default_nettype none

module rx_datapath_top (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire dsp_const_pkg::code_blk_t codes_i,
    input  wire dsp_cfg_pkg::wb_req_t     wb_req_i,
    output dsp_cfg_pkg::wb_rsp_t          wb_rsp_o,
    output dsp_const_pkg::bit_blk_t       bits_o,
    output dsp_const_pkg::err_blk_t       err_o,
    output logic                          valid_o
);

    import dsp_const_pkg::*;
    import dsp_cfg_pkg::*;

    dsp_cfg_t                cfg;
    bit_blk_t                sliced_bits;
    code_blk_t               codes_dly;
    logic [pipe_latency-1:0] fill_q;

    dsp_cfg_regs u_cfg_regs (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .cfg_o    (cfg)
    );

    ffe_slicer u_ffe_slicer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .codes_i (codes_i),
        .cfg_i   (cfg),
        .bits_o  (sliced_bits)
    );

    // ADC codes held until the channel estimate is ready
    lane_delay #(
        .payload_t (code_blk_t),
        .depth     (code_delay)
    ) u_code_delay (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .din_i   (codes_i),
        .dout_o  (codes_dly)
    );

    channel_error u_channel_error (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bits_i      (sliced_bits),
        .codes_dly_i (codes_dly),
        .cfg_i       (cfg),
        .err_o       (err_o)
    );

    // Bits lined up with the errors
    lane_delay #(
        .payload_t (bit_blk_t),
        .depth     (bit_delay)
    ) u_bit_delay (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .din_i   (sliced_bits),
        .dout_o  (bits_o)
    );

    // Pipeline fill after reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fill_q <= '0;
        end else begin
            fill_q <= {fill_q[pipe_latency-2:0], 1'b1};
        end
    end

    assign valid_o = fill_q[pipe_latency-1];

endmodule

`default_nettype wire

/* source/dsp_cfg_regs.sv */
`default_nettype none

module dsp_cfg_regs (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire dsp_cfg_pkg::wb_req_t wb_req_i,
    output dsp_cfg_pkg::wb_rsp_t      wb_rsp_o,
    output dsp_cfg_pkg::dsp_cfg_t     cfg_o
);

    import dsp_const_pkg::*;
    import dsp_cfg_pkg::*;

    dsp_cfg_t                cfg_q;
    logic                    ack_q;
    logic                    access;
    logic                    wr_en;
    logic [wb_dat_width-1:0] rd_data;
    logic [wb_dat_width-1:0] rd_data_q;
    logic [wb_dat_width-1:0] wr_data;

    // New transfer that is acked on the next edge
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = access && wb_req_i.we;

    always_comb begin
        rd_data = '0;
        case (wb_req_i.adr)
            reg_ffe_w0:     rd_data = wb_dat_width'($signed(cfg_q.ffe_weight[0]));
            reg_ffe_w1:     rd_data = wb_dat_width'($signed(cfg_q.ffe_weight[1]));
            reg_ffe_w2:     rd_data = wb_dat_width'($signed(cfg_q.ffe_weight[2]));
            reg_ffe_shift:  rd_data = wb_dat_width'(cfg_q.ffe_shift);
            reg_thresh:     rd_data = wb_dat_width'($signed(cfg_q.thresh));
            reg_chan_h0:    rd_data = wb_dat_width'($signed(cfg_q.chan_est[0]));
            reg_chan_h1:    rd_data = wb_dat_width'($signed(cfg_q.chan_est[1]));
            reg_chan_h2:    rd_data = wb_dat_width'($signed(cfg_q.chan_est[2]));
            reg_chan_shift: rd_data = wb_dat_width'(cfg_q.chan_shift);
            default:        rd_data = '0;
        endcase
    end

    // Unselected bytes keep the current register bits
    always_comb begin
        for (int b = 0; b < wb_sel_width; b++) begin
            if (wb_req_i.sel[b]) begin
                wr_data[8*b +: 8] = wb_req_i.dat[8*b +: 8];
            end else begin
                wr_data[8*b +: 8] = rd_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (wr_en) begin
                case (wb_req_i.adr)
                    reg_ffe_w0:     cfg_q.ffe_weight[0] <= wr_data[weight_width-1:0];
                    reg_ffe_w1:     cfg_q.ffe_weight[1] <= wr_data[weight_width-1:0];
                    reg_ffe_w2:     cfg_q.ffe_weight[2] <= wr_data[weight_width-1:0];
                    reg_ffe_shift:  cfg_q.ffe_shift     <= wr_data[shift_width-1:0];
                    reg_thresh:     cfg_q.thresh        <= wr_data[ffe_out_width-1:0];
                    reg_chan_h0:    cfg_q.chan_est[0]   <= wr_data[chan_est_width-1:0];
                    reg_chan_h1:    cfg_q.chan_est[1]   <= wr_data[chan_est_width-1:0];
                    reg_chan_h2:    cfg_q.chan_est[2]   <= wr_data[chan_est_width-1:0];
                    reg_chan_shift: cfg_q.chan_shift    <= wr_data[shift_width-1:0];
                    default:        cfg_q               <= cfg_q;
                endcase
            end
        end
    end

    // Read data captured with the transfer
    always_ff @(posedge clk_i) begin
        if (access) begin
            rd_data_q <= rd_data;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_data_q;
    assign cfg_o        = cfg_q;

endmodule

`default_nettype wire

/* channel/channel_error.sv */
`default_nettype none

module channel_error (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire dsp_const_pkg::bit_blk_t  bits_i,
    input  wire dsp_const_pkg::code_blk_t codes_dly_i,
    input  wire dsp_cfg_pkg::dsp_cfg_t    cfg_i,
    output dsp_const_pkg::err_blk_t       err_o
);

    import dsp_const_pkg::*;

    // Bit 0 is symbol -1 and a zero bit stands for a -1 symbol
    logic [chan_taps-2:0] bit_hist_q;
    err_blk_t             est_d;
    err_blk_t             est_q;

    // Channel filter taps applied to +1/-1 symbols
    always_comb begin
        logic signed [chan_acc_width-1:0] acc;
        logic                             b;
        for (int i = 0; i < lane_count; i++) begin
            acc = '0;
            for (int k = 0; k < chan_taps; k++) begin
                if (i >= k) begin
                    b = bits_i[i-k];
                end else begin
                    b = bit_hist_q[k-i-1];
                end
                if (b) begin
                    acc = acc + $signed(cfg_i.chan_est[k]);
                end else begin
                    acc = acc - $signed(cfg_i.chan_est[k]);
                end
            end
            acc = acc >>> cfg_i.chan_shift;
            est_d[i] = err_width'(sat_signed(acc, err_width));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            est_q      <= '0;
            bit_hist_q <= '0;
        end else begin
            est_q <= est_d;
            for (int k = 0; k < chan_taps - 1; k++) begin
                bit_hist_q[k] <= bits_i[lane_count-1-k];
            end
        end
    end

    // Estimate minus the ADC code of the same symbol
    always_ff @(posedge clk_i) begin
        logic signed [err_width:0] diff;
        if (!rst_n_i) begin
            err_o <= '0;
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                diff     = $signed(est_q[i]) - $signed(codes_dly_i[i]);
                err_o[i] <= err_width'(sat_signed(diff, err_width));
            end
        end
    end

endmodule

`default_nettype wire

/* ffe/ffe_slicer.sv */
`default_nettype none

module ffe_slicer (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire dsp_const_pkg::code_blk_t codes_i,
    input  wire dsp_cfg_pkg::dsp_cfg_t    cfg_i,
    output dsp_const_pkg::bit_blk_t       bits_o
);

    import dsp_const_pkg::*;

    // Entry 0 is symbol -1 from the previous block
    code_t    code_hist_q [ffe_taps-1];
    ffe_blk_t ffe_d;
    ffe_blk_t ffe_q;

    always_comb begin
        logic signed [ffe_acc_width-1:0] acc;
        code_t                           sym;
        for (int i = 0; i < lane_count; i++) begin
            acc = '0;
            for (int k = 0; k < ffe_taps; k++) begin
                if (i >= k) begin
                    sym = codes_i[i-k];
                end else begin
                    sym = code_hist_q[k-i-1];
                end
                acc = acc + $signed(sym) * $signed(cfg_i.ffe_weight[k]);
            end
            acc = acc >>> cfg_i.ffe_shift;
            ffe_d[i] = ffe_out_width'(sat_signed(acc, ffe_out_width));
        end
    end

    // FFE results registered one cycle after the codes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ffe_q <= '0;
            for (int k = 0; k < ffe_taps - 1; k++) begin
                code_hist_q[k] <= '0;
            end
        end else begin
            ffe_q <= ffe_d;
            for (int k = 0; k < ffe_taps - 1; k++) begin
                code_hist_q[k] <= codes_i[lane_count-1-k];
            end
        end
    end

    // Slicer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else begin
            for (int i = 0; i < lane_count; i++) begin
                bits_o[i] <= ($signed(ffe_q[i]) >= $signed(cfg_i.thresh));
            end
        end
    end

endmodule

`default_nettype wire

/* source/lane_delay.sv */
`default_nettype none

module lane_delay #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire payload_t din_i,
    output payload_t      dout_o
);

    payload_t stage_q [depth];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < depth; s++) begin
                stage_q[s] <= '0;
            end
        end else begin
            stage_q[0] <= din_i;
            for (int s = 1; s < depth; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    assign dout_o = stage_q[depth-1];

endmodule

`default_nettype wire

/* common/dsp_cfg_pkg.sv */
`default_nettype none

package dsp_cfg_pkg;

    localparam int wb_adr_width = 4;
    localparam int wb_dat_width = 16;
    localparam int wb_sel_width = wb_dat_width / 8;

    // Register map
    localparam logic [wb_adr_width-1:0] reg_ffe_w0     = 4'd0;
    localparam logic [wb_adr_width-1:0] reg_ffe_w1     = 4'd1;
    localparam logic [wb_adr_width-1:0] reg_ffe_w2     = 4'd2;
    localparam logic [wb_adr_width-1:0] reg_ffe_shift  = 4'd3;
    localparam logic [wb_adr_width-1:0] reg_thresh     = 4'd4;
    localparam logic [wb_adr_width-1:0] reg_chan_h0    = 4'd5;
    localparam logic [wb_adr_width-1:0] reg_chan_h1    = 4'd6;
    localparam logic [wb_adr_width-1:0] reg_chan_h2    = 4'd7;
    localparam logic [wb_adr_width-1:0] reg_chan_shift = 4'd8;

    typedef logic signed [dsp_const_pkg::weight_width-1:0]   weight_t;
    typedef logic signed [dsp_const_pkg::chan_est_width-1:0] chan_tap_t;

    typedef struct packed {
        weight_t [dsp_const_pkg::ffe_taps-1:0]           ffe_weight;
        logic [dsp_const_pkg::shift_width-1:0]           ffe_shift;
        logic signed [dsp_const_pkg::ffe_out_width-1:0]  thresh;
        chan_tap_t [dsp_const_pkg::chan_taps-1:0]        chan_est;
        logic [dsp_const_pkg::shift_width-1:0]           chan_shift;
    } dsp_cfg_t;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [wb_adr_width-1:0] adr;
        logic [wb_dat_width-1:0] dat;
        logic [wb_sel_width-1:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic                    ack;
        logic [wb_dat_width-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* common/dsp_const_pkg.sv */
`default_nettype none

package dsp_const_pkg;

    localparam int lane_count     = 4;
    localparam int code_width     = 8;
    localparam int ffe_taps       = 3;
    localparam int weight_width   = 8;
    localparam int ffe_out_width  = 10;
    localparam int shift_width    = 4;
    localparam int chan_taps      = 3;
    localparam int chan_est_width = 8;
    localparam int err_width      = 10;

    // Full-precision sums before the shift
    localparam int ffe_acc_width  = code_width + weight_width + 2;
    localparam int chan_acc_width = chan_est_width + 4;

    localparam int code_delay   = 3;
    localparam int bit_delay    = 2;
    localparam int pipe_latency = code_delay + 1;

    typedef logic signed [code_width-1:0]    code_t;
    typedef logic signed [ffe_out_width-1:0] ffe_t;
    typedef logic signed [err_width-1:0]     err_t;

    // Lane 0 holds the oldest symbol of a block
    typedef code_t [lane_count-1:0] code_blk_t;
    typedef logic  [lane_count-1:0] bit_blk_t;
    typedef ffe_t  [lane_count-1:0] ffe_blk_t;
    typedef err_t  [lane_count-1:0] err_blk_t;

    // Clamp to the range of a w-bit signed number
    function automatic logic signed [31:0] sat_signed(input logic signed [31:0] v,
                                                      input int w);
        logic signed [31:0] hi;
        logic signed [31:0] lo;
        logic signed [31:0] res;
        hi = (32'sd1 <<< (w - 1)) - 32'sd1;
        lo = -(32'sd1 <<< (w - 1));
        if (v > hi) begin
            res = hi;
        end else if (v < lo) begin
            res = lo;
        end else begin
            res = v;
        end
        return res;
    endfunction

endpackage

`default_nettype wire
